// ==== Bender.yml ====
package:
  name: iir_cascade

sources:
  - files:
      - common/iir_pkg.sv
      - common/sos_ctrl_if.sv
      - sos/iir_sos.sv
      - src/sos_sequencer.sv
      - src/iir_cascade.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_iir_cascade.sv

// ==== common/iir_pkg.sv ====
`default_nettype none

package iir_pkg;

  // sample word, signed q4.23
  localparam int samp_int  = 4;
  localparam int samp_frac = 23;
  localparam int samp_w    = samp_int + samp_frac;

  // coefficient word, signed q2.14
  localparam int coeff_int  = 2;
  localparam int coeff_frac = 14;
  localparam int coeff_w    = coeff_int + coeff_frac;

  // recursive state and accumulator, signed q8.24
  localparam int rec_int  = 8;
  localparam int rec_frac = 24;
  localparam int rec_w    = rec_int + rec_frac;

  // product widths of the feedback and output multipliers
  localparam int prod_w = rec_w + coeff_w;

  localparam int num_sections  = 3;
  localparam int section_idx_w = 2;

  // per-sample schedule
  typedef enum logic [1:0] {
    IDLE,
    MAC0,
    MAC1,
    COMMIT
  } seq_state_e;

  // coefficient select on the write bus, code 3 unused
  typedef enum logic [1:0] {
    TAP_A1 = 2'd0,
    TAP_A2 = 2'd1,
    TAP_B1 = 2'd2
  } coeff_tap_e;

endpackage

`default_nettype wire

// ==== common/sos_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sos_ctrl_if;
  import iir_pkg::*;

  // step strobes
  logic acc_clr;
  logic mac_en;
  logic mac_sel;
  logic commit;

  // coefficient write bus
  logic                     cw_en;
  logic [section_idx_w-1:0] cw_section;
  coeff_tap_e               cw_tap;
  logic [coeff_w-1:0]       cw_data;

  modport master (
    output acc_clr,
    output mac_en,
    output mac_sel,
    output commit,
    output cw_en,
    output cw_section,
    output cw_tap,
    output cw_data
  );

  modport section (
    input acc_clr,
    input mac_en,
    input mac_sel,
    input commit,
    input cw_en,
    input cw_section,
    input cw_tap,
    input cw_data
  );

endinterface

`default_nettype wire

// ==== iir_cascade.f ====
+incdir+tb
common/iir_pkg.sv
common/sos_ctrl_if.sv
sos/iir_sos.sv
src/sos_sequencer.sv
src/iir_cascade.sv
tb/tb_iir_cascade.sv

// ==== sos/iir_sos.sv ====
`timescale 1ns/1ps
`default_nettype none

module iir_sos #(
  parameter int unsigned section_id = 0
) (
  input  logic                        i_clk,
  input  logic                        acc_rst,
  input  logic [iir_pkg::samp_w-1:0]  din,
  sos_ctrl_if.section                 ctrl,
  output logic [iir_pkg::samp_w-1:0]  dout
);
  import iir_pkg::*;

  localparam logic [section_idx_w-1:0] my_section = section_idx_w'(section_id);
  localparam int guard_w = rec_int - samp_int;

  localparam logic [samp_w-1:0] samp_max = {1'b0, {(samp_w-1){1'b1}}};
  localparam logic [samp_w-1:0] samp_min = {1'b1, {(samp_w-1){1'b0}}};

  logic signed [coeff_w-1:0] a1;
  logic signed [coeff_w-1:0] a2;
  logic signed [coeff_w-1:0] b1;

  // w[n-1], w[n-2]
  logic signed [rec_w-1:0] w1;
  logic signed [rec_w-1:0] w2;
  logic signed [rec_w-1:0] acc;

  // error feedback residue per tap
  logic [coeff_frac-1:0] res [0:1];

  logic signed [rec_w-1:0]   sel_w;
  logic signed [coeff_w-1:0] sel_a;
  logic [coeff_frac-1:0]     sel_res;

  logic signed [prod_w-1:0] a_prod;
  logic [rec_w:0]           a_prod_top;
  logic [rec_w:0]           a_prod_inc;
  logic signed [rec_w-1:0]  a_prod_rnd;

  logic signed [prod_w-1:0] b_prod;
  logic [rec_w:0]           b_prod_top;
  logic [rec_w:0]           b_prod_inc;
  logic signed [rec_w-1:0]  b_prod_rnd;

  logic signed [rec_w-1:0] din_ext;
  logic signed [rec_w-1:0] w_new;
  logic signed [rec_w-1:0] y;

  logic [samp_w:0]     y_top;
  logic [samp_w:0]     y_inc;
  logic [guard_w-1:0]  y_guard;
  logic                ovf_pos;
  logic                ovf_neg;
  logic [samp_w-1:0]   y_sat;

  // tap mux for the shared feedback multiplier
  assign sel_w   = ctrl.mac_sel ? w2 : w1;
  assign sel_a   = ctrl.mac_sel ? a2 : a1;
  assign sel_res = ctrl.mac_sel ? res[1] : res[0];

  assign a_prod = sel_w * sel_a + $signed({{(prod_w-coeff_frac){1'b0}}, sel_res});

  // half-up rounding, one bit below the rec_frac lsb
  assign a_prod_top = a_prod[rec_w+coeff_frac-1 -: rec_w+1];
  assign a_prod_inc = a_prod_top + 1'b1;
  assign a_prod_rnd = a_prod_inc[rec_w:1];

  // output tap b1 on the old w[n-1]
  assign b_prod     = w1 * b1;
  assign b_prod_top = b_prod[rec_w+coeff_frac-1 -: rec_w+1];
  assign b_prod_inc = b_prod_top + 1'b1;
  assign b_prod_rnd = b_prod_inc[rec_w:1];

  // input aligned to the recursive format
  assign din_ext = {{guard_w{din[samp_w-1]}}, din, {(rec_frac-samp_frac){1'b0}}};

  assign w_new = din_ext + acc;
  assign y     = w_new + b_prod_rnd + w2;

  // round y to samp_frac
  assign y_top = y[samp_int+rec_frac-1 -: samp_w+1];
  assign y_inc = y_top + 1'b1;

  assign y_guard = y[rec_w-2 -: guard_w];

  // rounding can also carry a positive value past the top code
  assign ovf_pos = !y[rec_w-1] && ((|y_guard) || (!y_top[samp_w] && y_inc[samp_w]));
  assign ovf_neg = y[rec_w-1] && !(&y_guard);

  always_comb begin
    if (ovf_pos) begin
      y_sat = samp_max;
    end else if (ovf_neg) begin
      y_sat = samp_min;
    end else begin
      y_sat = y_inc[samp_w:1];
    end
  end

  always_ff @(posedge i_clk or negedge acc_rst) begin
    if (!acc_rst) begin
      a1 <= '0;
      a2 <= '0;
      b1 <= '0;
    end else if (ctrl.cw_en && (ctrl.cw_section == my_section)) begin
      case (ctrl.cw_tap)
        TAP_A1: a1 <= ctrl.cw_data;
        TAP_A2: a2 <= ctrl.cw_data;
        TAP_B1: b1 <= ctrl.cw_data;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge acc_rst) begin
    if (!acc_rst) begin
      acc <= '0;
    end else if (ctrl.acc_clr) begin
      acc <= '0;
    end else if (ctrl.mac_en) begin
      acc <= acc + a_prod_rnd;
    end
  end

  // discarded fraction of each tap feeds its next product
  always_ff @(posedge i_clk or negedge acc_rst) begin
    if (!acc_rst) begin
      res[0] <= '0;
      res[1] <= '0;
    end else if (ctrl.mac_en) begin
      if (ctrl.mac_sel) begin
        res[1] <= a_prod[coeff_frac-1:0];
      end else begin
        res[0] <= a_prod[coeff_frac-1:0];
      end
    end
  end

  always_ff @(posedge i_clk or negedge acc_rst) begin
    if (!acc_rst) begin
      w1   <= '0;
      w2   <= '0;
      dout <= '0;
    end else if (ctrl.commit) begin
      w1   <= w_new;
      w2   <= w1;
      dout <= y_sat;
    end
  end

endmodule

`default_nettype wire

// ==== src/iir_cascade.sv ====
`timescale 1ns/1ps
`default_nettype none

module iir_cascade (
  input  logic                               i_clk,
  input  logic                               acc_rst,
  input  logic                               in_valid,
  input  logic [iir_pkg::samp_w-1:0]         in_sample,
  input  logic                               coeff_we,
  input  logic [iir_pkg::section_idx_w-1:0]  coeff_section,
  input  iir_pkg::coeff_tap_e                coeff_tap,
  input  logic [iir_pkg::coeff_w-1:0]        coeff_data,
  output logic                               out_valid,
  output logic [iir_pkg::samp_w-1:0]         out_sample
);
  import iir_pkg::*;

  sos_ctrl_if ctrl ();

  // chain[k] feeds section k, chain[num_sections] is the filter output
  logic [samp_w-1:0] chain [0:num_sections];

  assign chain[0] = in_sample;

  sos_sequencer i_sos_sequencer (
    .i_clk         (i_clk),
    .acc_rst       (acc_rst),
    .in_valid      (in_valid),
    .coeff_we      (coeff_we),
    .coeff_section (coeff_section),
    .coeff_tap     (coeff_tap),
    .coeff_data    (coeff_data),
    .out_valid     (out_valid),
    .ctrl          (ctrl.master)
  );

  for (genvar k = 0; k < num_sections; k++) begin : g_sos
    iir_sos #(
      .section_id (k)
    ) i_iir_sos (
      .i_clk   (i_clk),
      .acc_rst (acc_rst),
      .din     (chain[k]),
      .ctrl    (ctrl.section),
      .dout    (chain[k+1])
    );
  end

  assign out_sample = chain[num_sections];

endmodule

`default_nettype wire

// ==== src/sos_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sos_sequencer (
  input  logic                               i_clk,
  input  logic                               acc_rst,
  input  logic                               in_valid,
  input  logic                               coeff_we,
  input  logic [iir_pkg::section_idx_w-1:0]  coeff_section,
  input  iir_pkg::coeff_tap_e                coeff_tap,
  input  logic [iir_pkg::coeff_w-1:0]        coeff_data,
  output logic                               out_valid,
  sos_ctrl_if.master                         ctrl
);
  import iir_pkg::*;

  seq_state_e state;
  seq_state_e state_nxt;
  logic       accept;

  // one-entry write buffer
  logic                     pend_valid;
  logic [section_idx_w-1:0] pend_section;
  coeff_tap_e               pend_tap;
  logic [coeff_w-1:0]       pend_data;

  assign accept = (state == IDLE) && in_valid;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    state_nxt = in_valid ? MAC0 : IDLE;
      MAC0:    state_nxt = MAC1;
      MAC1:    state_nxt = COMMIT;
      COMMIT:  state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge acc_rst) begin
    if (!acc_rst) begin
      state     <= IDLE;
      out_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      out_valid <= (state == COMMIT);
    end
  end

  // a newer write replaces the pending one
  always_ff @(posedge i_clk or negedge acc_rst) begin
    if (!acc_rst) begin
      pend_valid <= 1'b0;
    end else if (coeff_we) begin
      pend_valid <= 1'b1;
    end else if (state == IDLE) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (coeff_we) begin
      pend_section <= coeff_section;
      pend_tap     <= coeff_tap;
      pend_data    <= coeff_data;
    end
  end

  assign ctrl.acc_clr = accept;
  assign ctrl.mac_en  = (state == MAC0) || (state == MAC1);
  assign ctrl.mac_sel = (state == MAC1);
  assign ctrl.commit  = (state == COMMIT);

  // writes land only between samples
  assign ctrl.cw_en      = pend_valid && (state == IDLE);
  assign ctrl.cw_section = pend_section;
  assign ctrl.cw_tap     = pend_tap;
  assign ctrl.cw_data    = pend_data;

endmodule

`default_nettype wire

// ==== tb/iir_ref.svh ====
`ifndef IIR_REF_SVH
`define IIR_REF_SVH
`default_nettype none

// reference model state, one entry per section
logic signed [coeff_w-1:0] m_a1 [num_sections];
logic signed [coeff_w-1:0] m_a2 [num_sections];
logic signed [coeff_w-1:0] m_b1 [num_sections];
logic signed [rec_w-1:0]   m_w1 [num_sections];
logic signed [rec_w-1:0]   m_w2 [num_sections];
logic [coeff_frac-1:0]     m_res0 [num_sections];
logic [coeff_frac-1:0]     m_res1 [num_sections];
logic [samp_w-1:0]         m_dout [num_sections];

logic [15:0] lfsr_state;

// fibonacci lfsr, taps 16 14 13 11
function automatic logic [63:0] rand_bits(input int n);
  logic [63:0] v;
  logic        fb;
  int          i;
  v = '0;
  for (i = 0; i < n; i++) begin
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    v = {v[62:0], fb};
  end
  return v;
endfunction

// half-up rounding of a product down to rec_frac
function automatic logic signed [rec_w-1:0] round_prod(input longint p);
  longint t;
  t = (p + 8192) >>> coeff_frac;
  return t[rec_w-1:0];
endfunction

function automatic logic [samp_w-1:0] ref_section(input int k, input logic [samp_w-1:0] din);
  logic signed [samp_w-1:0] ds;
  logic signed [rec_w-1:0]  acc;
  logic signed [rec_w-1:0]  w_new;
  logic signed [rec_w-1:0]  y;
  longint                   p;
  longint                   r;
  longint                   t;
  ds  = din;
  p   = longint'(m_w1[k]) * longint'(m_a1[k]) + longint'(m_res0[k]);
  m_res0[k] = p[coeff_frac-1:0];
  acc = round_prod(p);
  p   = longint'(m_w2[k]) * longint'(m_a2[k]) + longint'(m_res1[k]);
  m_res1[k] = p[coeff_frac-1:0];
  acc = acc + round_prod(p);
  t     = longint'(ds) * 2 + longint'(acc);
  w_new = t[rec_w-1:0];
  y     = w_new + round_prod(longint'(m_w1[k]) * longint'(m_b1[k])) + m_w2[k];
  r     = (longint'(y) + 1) >>> 1;
  if (r > (64'sd1 <<< (samp_w-1)) - 1) begin
    r = (64'sd1 <<< (samp_w-1)) - 1;
  end else if (r < -(64'sd1 <<< (samp_w-1))) begin
    r = -(64'sd1 <<< (samp_w-1));
  end
  m_w2[k]   = m_w1[k];
  m_w1[k]   = w_new;
  m_dout[k] = r[samp_w-1:0];
  return m_dout[k];
endfunction

// all sections commit together on the old outputs of their predecessors
function automatic logic [samp_w-1:0] ref_cascade(input logic [samp_w-1:0] x);
  int                k;
  logic [samp_w-1:0] d;
  for (k = num_sections - 1; k >= 0; k--) begin
    d = (k == 0) ? x : m_dout[k-1];
    void'(ref_section(k, d));
  end
  return m_dout[num_sections-1];
endfunction

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (exp !== act) begin
    $display("[FAIL] %s expected %h actual %h", name, exp, act);
    $display("FAIL: see errors above");
    $fatal(1);
  end
endtask

`default_nettype wire
`endif

// ==== tb/tb_iir_cascade.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_iir_cascade;
  import iir_pkg::*;

  logic              i_clk;
  logic              acc_rst;
  logic              in_valid;
  logic [samp_w-1:0] in_sample;
  logic              coeff_we;
  logic [section_idx_w-1:0] coeff_section;
  coeff_tap_e        coeff_tap;
  logic [coeff_w-1:0] coeff_data;
  logic              out_valid;
  logic [samp_w-1:0] out_sample;

  logic [samp_w-1:0] exp_q [$];
  string             test_name;
  int                n_out;
  int                n_sent;

  `include "iir_ref.svh"

  iir_cascade i_iir_cascade (
    .i_clk         (i_clk),
    .acc_rst       (acc_rst),
    .in_valid      (in_valid),
    .in_sample     (in_sample),
    .coeff_we      (coeff_we),
    .coeff_section (coeff_section),
    .coeff_tap     (coeff_tap),
    .coeff_data    (coeff_data),
    .out_valid     (out_valid),
    .out_sample    (out_sample)
  );

  always #2 i_clk = ~i_clk;

  // outputs are settled at the falling edge
  always @(negedge i_clk) begin
    if (acc_rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid pulsed with no sample outstanding in %s", test_name);
        $display("FAIL: see errors above");
        $fatal(1);
      end else begin
        check_value(test_name, exp_q.pop_front(), out_sample);
        n_out++;
      end
    end
  end

  task automatic wait_out_valid();
    int cnt;
    cnt = 0;
    @(negedge i_clk);
    while (!out_valid) begin
      cnt++;
      if (cnt > 20) begin
        $display("timeout waiting for out_valid in %s", test_name);
        $display("FAIL: see errors above");
        $fatal(1);
      end
      @(negedge i_clk);
    end
  endtask

  task automatic write_coeff(input int sec, input coeff_tap_e tap, input logic [coeff_w-1:0] d);
    @(negedge i_clk);
    coeff_we      = 1'b1;
    coeff_section = sec[section_idx_w-1:0];
    coeff_tap     = tap;
    coeff_data    = d;
    @(negedge i_clk);
    coeff_we = 1'b0;
    repeat (2) @(negedge i_clk);
    case (tap)
      TAP_A1: m_a1[sec] = d;
      TAP_A2: m_a2[sec] = d;
      default: m_b1[sec] = d;
    endcase
  endtask

  // mode 1 adds a coefficient write in MAC0, mode 2 a strobe in MAC1
  task automatic send_sample(input logic [samp_w-1:0] x, input int mode);
    @(negedge i_clk);
    in_valid  = 1'b1;
    in_sample = x;
    exp_q.push_back(ref_cascade(x));
    n_sent++;
    @(negedge i_clk);
    in_valid = 1'b0;
    if (mode == 1) begin
      coeff_we      = 1'b1;
      coeff_section = 2'd1;
      coeff_tap     = TAP_B1;
      coeff_data    = 16'h2000;
      @(negedge i_clk);
      coeff_we = 1'b0;
      m_b1[1]  = 16'h2000;
    end else if (mode == 2) begin
      @(negedge i_clk);
      in_valid  = 1'b1;
      in_sample = ~x;
      @(negedge i_clk);
      in_valid  = 1'b0;
      // section 0 takes in_sample at commit
      in_sample = x;
    end
    wait_out_valid();
  endtask

  function automatic logic [samp_w-1:0] rand_sample();
    logic signed [23:0]       s24;
    logic signed [samp_w-1:0] s;
    s24 = rand_bits(24);
    s   = s24;
    return s;
  endfunction

  function automatic logic [coeff_w-1:0] rand_coeff();
    logic signed [12:0]        c13;
    logic signed [coeff_w-1:0] c;
    c13 = rand_bits(13);
    c   = c13;
    return c;
  endfunction

  initial begin
    int i;
    int k;
    i_clk = 1'b0;
    acc_rst = 1'b0;
    in_valid = 1'b0;
    in_sample = '0;
    coeff_we = 1'b0;
    coeff_section = '0;
    coeff_tap = TAP_A1;
    coeff_data = '0;
    lfsr_state = 16'd27;
    n_out = 0;
    n_sent = 0;
    for (k = 0; k < num_sections; k++) begin
      m_a1[k] = '0;
      m_a2[k] = '0;
      m_b1[k] = '0;
      m_w1[k] = '0;
      m_w2[k] = '0;
      m_res0[k] = '0;
      m_res1[k] = '0;
      m_dout[k] = '0;
    end
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    acc_rst = 1'b1;

    test_name = "reset_state";
    repeat (10) @(negedge i_clk);
    check_value("reset_state out_valid", 64'd0, {63'd0, out_valid});
    send_sample(27'h0400000, 0);
    check_value("reset_state output", 64'd0, {37'd0, out_sample});

    test_name = "pass_through";
    for (i = 0; i < 12; i++) begin
      send_sample(rand_sample(), 0);
    end

    test_name = "random_coeffs";
    for (k = 0; k < num_sections; k++) begin
      write_coeff(k, TAP_A1, rand_coeff());
      write_coeff(k, TAP_A2, rand_coeff());
      write_coeff(k, TAP_B1, rand_coeff());
    end
    for (i = 0; i < 40; i++) begin
      send_sample(rand_sample(), 0);
    end

    test_name = "saturation";
    for (k = 0; k < num_sections; k++) begin
      write_coeff(k, TAP_A1, 16'h2000);
      write_coeff(k, TAP_A2, 16'h0000);
      write_coeff(k, TAP_B1, 16'h2000);
    end
    for (i = 0; i < 8; i++) begin
      send_sample(27'h3000000, 0);
    end
    check_value("saturation max", {37'd0, 27'h3ffffff}, {37'd0, out_sample});
    for (i = 0; i < 12; i++) begin
      send_sample(27'h5000000, 0);
    end
    check_value("saturation min", {37'd0, 27'h4000000}, {37'd0, out_sample});

    test_name = "deferred_write";
    for (k = 0; k < num_sections; k++) begin
      write_coeff(k, TAP_A1, rand_coeff());
      write_coeff(k, TAP_B1, rand_coeff());
    end
    send_sample(rand_sample(), 1);
    for (i = 0; i < 6; i++) begin
      send_sample(rand_sample(), 0);
    end

    test_name = "dropped_input";
    send_sample(rand_sample(), 2);
    send_sample(rand_sample(), 0);
    repeat (10) @(negedge i_clk);
    check_value("output count", n_sent, n_out);

    $display("PASS: all tests");
    $finish;
  end

  // guard against a stuck run
  initial begin
    #200000;
    $display("simulation time limit reached");
    $display("FAIL: see errors above");
    $fatal(1);
  end

endmodule

`default_nettype wire
